// File: src/floo_vc_pkg.sv
// shared types and constants of the virtual-channel mesh router
package floo_vc_pkg;

  // ==================================================
  // router dimensions
  // ==================================================

  // one port per mesh direction plus the local port
  localparam int NumPorts = 5;
  // vc id on links and in credit returns
  localparam int VcIdWidth = 2;
  localparam int PayloadWidth = 32;

  // ==================================================
  // header types
  // ==================================================

  // output direction, the enum order is also the port index
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } route_dir_e;

  // mesh coordinate, north is +y and east is +x
  typedef struct packed {
    logic [2:0] x;
    logic [2:0] y;
  } coord_t;

  typedef struct packed {
    coord_t                 dst;
    // output to take at the router that receives this flit
    route_dir_e             lookahead;
    // vc on the link the flit travels over
    logic [VcIdWidth-1:0]   vc_id;
  } hdr_t;

  // single-flit packet
  typedef struct packed {
    hdr_t                    hdr;
    logic [PayloadWidth-1:0] payload;
  } flit_t;

endpackage

// File: src/floo_input_port.sv
`timescale 1ns/100ps
// input port with one circular flit FIFO per VC and upstream credit return
module floo_input_port #(
  parameter int NumVC   = 3,
  parameter int VCDepth = 2
) (
  input  logic                                                clk_i,
  input  logic                                                reset_i,
  // link from upstream router, one-hot over VCs
  input  logic [NumVC-1:0]                                    data_v_i,
  input  floo_vc_pkg::flit_t                                  data_i,
  // credit back to upstream
  output logic                                                credit_v_o,
  output logic [floo_vc_pkg::VcIdWidth-1:0]                   credit_id_o,
  // fifo heads towards allocation and traversal
  output logic [NumVC-1:0]                                    vc_head_v_o,
  output floo_vc_pkg::hdr_t [NumVC-1:0]                       vc_head_o,
  output logic [NumVC-1:0][floo_vc_pkg::PayloadWidth-1:0]     vc_data_head_o,
  // pop from switch traversal
  input  logic                                                read_en_i,
  input  logic [floo_vc_pkg::VcIdWidth-1:0]                   read_vc_id_i
);
  import floo_vc_pkg::*;

  localparam int PtrW = (VCDepth > 1) ? $clog2(VCDepth) : 1;
  localparam int CntW = $clog2(VCDepth + 1);

  flit_t                       mem [NumVC][VCDepth];
  logic [NumVC-1:0][PtrW-1:0]  wr_ptr;
  logic [NumVC-1:0][PtrW-1:0]  rd_ptr;
  logic [NumVC-1:0][CntW-1:0]  count;
  logic [NumVC-1:0]            pop;

  function automatic logic [PtrW-1:0] wrap_inc(logic [PtrW-1:0] p);
    return (p == PtrW'(VCDepth - 1)) ? '0 : p + 1'b1;
  endfunction

  for (genvar v = 0; v < NumVC; v++) begin : gen_vc
    assign pop[v]            = read_en_i && (read_vc_id_i == VcIdWidth'(v));
    assign vc_head_v_o[v]    = (count[v] != '0);
    assign vc_head_o[v]      = mem[v][rd_ptr[v]].hdr;
    assign vc_data_head_o[v] = mem[v][rd_ptr[v]].payload;

    // upstream only sends with a credit, so a full fifo never sees a write
    assert property (@(posedge clk_i) disable iff (reset_i)
      data_v_i[v] |-> (count[v] < CntW'(VCDepth)));
  end

  // flit storage, written in the arrival cycle
  always_ff @(posedge clk_i) begin
    for (int v = 0; v < NumVC; v++) begin
      if (data_v_i[v]) begin
        mem[v][wr_ptr[v]] <= data_i;
      end
    end
  end

  // pointers and fill levels
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      for (int v = 0; v < NumVC; v++) begin
        if (data_v_i[v]) wr_ptr[v] <= wrap_inc(wr_ptr[v]);
        if (pop[v]) rd_ptr[v] <= wrap_inc(rd_ptr[v]);
        if (data_v_i[v] && !pop[v]) count[v] <= count[v] + 1'b1;
        else if (pop[v] && !data_v_i[v]) count[v] <= count[v] - 1'b1;
      end
    end
  end

  // every pop frees one slot, credit goes out with the flit on data_v_o
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_v_o  <= 1'b0;
      credit_id_o <= '0;
    end else begin
      credit_v_o  <= read_en_i;
      credit_id_o <= read_vc_id_i;
    end
  end

  // the allocators only grant a head that is present
  assert property (@(posedge clk_i) disable iff (reset_i)
    read_en_i |-> vc_head_v_o[read_vc_id_i]);

endmodule

// File: src/floo_sa_local.sv
`timescale 1ns/100ps
// local switch allocator, round-robin choice of one ready VC per input
module floo_sa_local #(
  parameter int NumVC = 3
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic [NumVC-1:0]                      vc_head_v_i,
  input  floo_vc_pkg::hdr_t [NumVC-1:0]         vc_head_i,
  // per output: some downstream vc has a credit
  input  logic [floo_vc_pkg::NumPorts-1:0]      out_vc_avail_i,
  output logic                                  req_v_o,
  output logic [floo_vc_pkg::NumPorts-1:0]      req_dir_oh_o,
  output logic [floo_vc_pkg::VcIdWidth-1:0]     req_vc_id_o,
  // winner was popped this cycle
  input  logic                                  update_i
);
  import floo_vc_pkg::*;

  logic [NumVC-1:0]           elig;
  logic [VcIdWidth-1:0]       ptr;

  // drop heads whose look-ahead output is out of credits
  always_comb begin
    for (int v = 0; v < NumVC; v++) begin
      elig[v] = vc_head_v_i[v] & out_vc_avail_i[vc_head_i[v].lookahead];
    end
  end

  // search starts at ptr and wraps around once
  always_comb begin
    int idx;
    req_v_o     = 1'b0;
    req_vc_id_o = '0;
    for (int k = 0; k < NumVC; k++) begin
      idx = int'(ptr) + k;
      if (idx >= NumVC) idx = idx - NumVC;
      if (elig[idx] && !req_v_o) begin
        req_v_o     = 1'b1;
        req_vc_id_o = VcIdWidth'(idx);
      end
    end
    // one-hot output of the winning head
    req_dir_oh_o = '0;
    if (req_v_o) req_dir_oh_o[vc_head_i[req_vc_id_o].lookahead] = 1'b1;
  end

  // pointer moves just past the vc that was served
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr <= '0;
    end else if (update_i) begin
      ptr <= (req_vc_id_o == VcIdWidth'(NumVC - 1)) ? '0 : req_vc_id_o + 1'b1;
    end
  end

endmodule

// File: src/floo_sa_global.sv
`timescale 1ns/100ps
// global switch allocator that picks one input per output in round-robin order
module floo_sa_global (
  input  logic                                                          clk_i,
  input  logic                                                          reset_i,
  // one request bit per input
  input  logic [floo_vc_pkg::NumPorts-1:0]                              req_v_i,
  input  logic [floo_vc_pkg::NumPorts-1:0][floo_vc_pkg::VcIdWidth-1:0]  req_vc_id_i,
  output logic                                                          grant_v_o,
  output logic [floo_vc_pkg::NumPorts-1:0]                              grant_in_oh_o,
  output logic [floo_vc_pkg::VcIdWidth-1:0]                             grant_vc_id_o,
  input  logic                                                          update_i
);
  import floo_vc_pkg::*;

  localparam int InIdxW = $clog2(NumPorts);

  logic [InIdxW-1:0] ptr;
  logic [InIdxW-1:0] winner;

  // first requester at or after ptr
  always_comb begin
    int idx;
    grant_v_o = 1'b0;
    winner    = '0;
    for (int k = 0; k < NumPorts; k++) begin
      idx = int'(ptr) + k;
      if (idx >= NumPorts) idx = idx - NumPorts;
      if (req_v_i[idx] && !grant_v_o) begin
        grant_v_o = 1'b1;
        winner    = InIdxW'(idx);
      end
    end
  end

  always_comb begin
    grant_in_oh_o = '0;
    if (grant_v_o) grant_in_oh_o[winner] = 1'b1;
  end

  // vc of the winning input goes along for the pop
  assign grant_vc_id_o = req_vc_id_i[winner];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr <= '0;
    end else if (update_i) begin
      ptr <= (winner == InIdxW'(NumPorts - 1)) ? '0 : winner + 1'b1;
    end
  end

endmodule

// File: src/floo_vc_credit_tracker.sv
`timescale 1ns/100ps
// downstream credit counters of one output and lowest free VC selection
module floo_vc_credit_tracker #(
  parameter int NumVC   = 3,
  parameter int VCDepth = 2
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  // a flit was granted to this output
  input  logic                                consume_i,
  // credit back from the downstream router
  input  logic                                credit_v_i,
  input  logic [floo_vc_pkg::VcIdWidth-1:0]   credit_id_i,
  output logic                                out_vc_avail_o,
  output logic [floo_vc_pkg::VcIdWidth-1:0]   out_vc_id_o
);
  import floo_vc_pkg::*;

  localparam int CntW = $clog2(VCDepth + 1);

  logic [NumVC-1:0][CntW-1:0] cnt;
  logic [NumVC-1:0]           has_credit;
  logic [NumVC-1:0]           inc;
  logic [NumVC-1:0]           dec;

  always_comb begin
    for (int v = 0; v < NumVC; v++) begin
      has_credit[v] = (cnt[v] != '0);
      inc[v]        = credit_v_i && (credit_id_i == VcIdWidth'(v));
      dec[v]        = consume_i && (out_vc_id_o == VcIdWidth'(v));
    end
  end

  // lowest index wins, scan from the top down
  always_comb begin
    out_vc_avail_o = |has_credit;
    out_vc_id_o    = '0;
    for (int v = NumVC - 1; v >= 0; v--) begin
      if (has_credit[v]) out_vc_id_o = VcIdWidth'(v);
    end
  end

  // a return and a grant on the same vc cancel out
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int v = 0; v < NumVC; v++) cnt[v] <= CntW'(VCDepth);
    end else begin
      for (int v = 0; v < NumVC; v++) begin
        if (inc[v] && !dec[v]) cnt[v] <= cnt[v] + 1'b1;
        else if (dec[v] && !inc[v]) cnt[v] <= cnt[v] - 1'b1;
      end
    end
  end

  // global allocation only grants outputs that still hold a credit
  assert property (@(posedge clk_i) disable iff (reset_i)
    consume_i |-> out_vc_avail_o);

  // downstream never returns more than it was sent
  assert property (@(posedge clk_i) disable iff (reset_i)
    credit_v_i |-> (cnt[credit_id_i] < CntW'(VCDepth)) || dec[credit_id_i]);

endmodule

// File: src/floo_switch_traversal.sv
`timescale 1ns/100ps
// allocation to traversal stage, crossbar and next-hop look-ahead XY routing
module floo_switch_traversal #(
  parameter int NumVC = 3
) (
  input  logic                                                          clk_i,
  input  logic                                                          reset_i,
  input  floo_vc_pkg::coord_t                                           xy_id_i,
  // per output: grant, winning input and its vc
  input  logic [floo_vc_pkg::NumPorts-1:0]                              grant_v_i,
  input  logic [floo_vc_pkg::NumPorts-1:0][floo_vc_pkg::NumPorts-1:0]   grant_in_oh_i,
  input  logic [floo_vc_pkg::NumPorts-1:0][floo_vc_pkg::VcIdWidth-1:0]  grant_vc_id_i,
  // per output: downstream vc picked by the credit tracker
  input  logic [floo_vc_pkg::NumPorts-1:0][floo_vc_pkg::VcIdWidth-1:0]  out_vc_id_i,
  input  floo_vc_pkg::hdr_t [floo_vc_pkg::NumPorts-1:0][NumVC-1:0]      vc_head_i,
  input  logic [floo_vc_pkg::NumPorts-1:0][NumVC-1:0]
               [floo_vc_pkg::PayloadWidth-1:0]                          vc_data_head_i,
  // per input pop
  output logic [floo_vc_pkg::NumPorts-1:0]                              read_en_o,
  output logic [floo_vc_pkg::NumPorts-1:0][floo_vc_pkg::VcIdWidth-1:0]  read_vc_id_o,
  output logic [floo_vc_pkg::NumPorts-1:0][NumVC-1:0]                   data_v_o,
  output floo_vc_pkg::flit_t [floo_vc_pkg::NumPorts-1:0]                data_o
);
  import floo_vc_pkg::*;

  localparam int InIdxW = $clog2(NumPorts);

  flit_t [NumPorts-1:0] st_flit;

  // dimension order, x first then y
  function automatic route_dir_e xy_route(coord_t here, coord_t dst);
    if (dst.x > here.x) return East;
    if (dst.x < here.x) return West;
    if (dst.y > here.y) return North;
    if (dst.y < here.y) return South;
    return Eject;
  endfunction

  // ==================================================
  // input pops
  // ==================================================

  // each input requests one output, so at most one grant hits it
  always_comb begin
    read_en_o    = '0;
    read_vc_id_o = '0;
    for (int o = 0; o < NumPorts; o++) begin
      for (int i = 0; i < NumPorts; i++) begin
        if (grant_v_i[o] && grant_in_oh_i[o][i]) begin
          read_en_o[i]    = 1'b1;
          read_vc_id_o[i] = grant_vc_id_i[o];
        end
      end
    end
  end

  // ==================================================
  // crossbar and look-ahead rewrite
  // ==================================================

  for (genvar o = 0; o < NumPorts; o++) begin : gen_out
    logic [InIdxW-1:0] in_sel;
    coord_t            nbr;
    flit_t             sel;

    always_comb begin
      in_sel = '0;
      for (int i = 0; i < NumPorts; i++) begin
        if (grant_in_oh_i[o][i]) in_sel = InIdxW'(i);
      end
    end

    // coordinate of the router behind this output
    always_comb begin
      nbr = xy_id_i;
      case (o)
        North:   nbr.y = xy_id_i.y + 3'd1;
        East:    nbr.x = xy_id_i.x + 3'd1;
        South:   nbr.y = xy_id_i.y - 3'd1;
        West:    nbr.x = xy_id_i.x - 3'd1;
        default: nbr   = xy_id_i;
      endcase
    end

    always_comb begin
      sel.hdr           = vc_head_i[in_sel][grant_vc_id_i[o]];
      sel.payload       = vc_data_head_i[in_sel][grant_vc_id_i[o]];
      sel.hdr.vc_id     = out_vc_id_i[o];
      sel.hdr.lookahead = xy_route(nbr, sel.hdr.dst);
    end

    assign st_flit[o] = sel;
  end

  // ==================================================
  // stage register
  // ==================================================

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_v_o <= '0;
    end else begin
      for (int o = 0; o < NumPorts; o++) begin
        data_v_o[o] <= grant_v_i[o] ? (NumVC'(1) << out_vc_id_i[o]) : '0;
      end
    end
  end

  // payload only moves on a grant
  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NumPorts; o++) begin
      if (grant_v_i[o]) data_o[o] <= st_flit[o];
    end
  end

endmodule

// File: src/floo_vc_router.sv
`timescale 1ns/100ps
// five-port credit-based VC mesh router with two-stage switch allocation
module floo_vc_router #(
  parameter int NumVC   = 3,
  parameter int VCDepth = 2
) (
  input  logic                                                          clk_i,
  input  logic                                                          reset_i,
  input  floo_vc_pkg::coord_t                                           xy_id_i,
  // input side links
  output logic [floo_vc_pkg::NumPorts-1:0]                              credit_v_o,
  output logic [floo_vc_pkg::NumPorts-1:0][floo_vc_pkg::VcIdWidth-1:0]  credit_id_o,
  input  logic [floo_vc_pkg::NumPorts-1:0][NumVC-1:0]                   data_v_i,
  input  floo_vc_pkg::flit_t [floo_vc_pkg::NumPorts-1:0]                data_i,
  // output side links
  input  logic [floo_vc_pkg::NumPorts-1:0]                              credit_v_i,
  input  logic [floo_vc_pkg::NumPorts-1:0][floo_vc_pkg::VcIdWidth-1:0]  credit_id_i,
  output logic [floo_vc_pkg::NumPorts-1:0][NumVC-1:0]                   data_v_o,
  output floo_vc_pkg::flit_t [floo_vc_pkg::NumPorts-1:0]                data_o
);
  import floo_vc_pkg::*;

  // fifo heads
  logic  [NumPorts-1:0][NumVC-1:0]                    vc_head_v;
  hdr_t  [NumPorts-1:0][NumVC-1:0]                    vc_head;
  logic  [NumPorts-1:0][NumVC-1:0][PayloadWidth-1:0]  vc_data_head;
  // pops from traversal
  logic  [NumPorts-1:0]                               read_en;
  logic  [NumPorts-1:0][VcIdWidth-1:0]                read_vc_id;
  // local allocation, indexed by input
  logic  [NumPorts-1:0]                               sa_local_v;
  logic  [NumPorts-1:0][NumPorts-1:0]                 sa_local_dir_oh;
  logic  [NumPorts-1:0][VcIdWidth-1:0]                sa_local_vc_id;
  // global allocation and credits, indexed by output
  logic  [NumPorts-1:0][NumPorts-1:0]                 req_v_per_out;
  logic  [NumPorts-1:0]                               sa_global_v;
  logic  [NumPorts-1:0][NumPorts-1:0]                 sa_global_in_oh;
  logic  [NumPorts-1:0][VcIdWidth-1:0]                sa_global_vc_id;
  logic  [NumPorts-1:0]                               out_vc_avail;
  logic  [NumPorts-1:0][VcIdWidth-1:0]                out_vc_id;

  // ==================================================
  // input ports and local allocation
  // ==================================================

  for (genvar i = 0; i < NumPorts; i++) begin : gen_in
    floo_input_port #(
      .NumVC   (NumVC),
      .VCDepth (VCDepth)
    ) i_input_port (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .data_v_i       (data_v_i[i]),
      .data_i         (data_i[i]),
      .credit_v_o     (credit_v_o[i]),
      .credit_id_o    (credit_id_o[i]),
      .vc_head_v_o    (vc_head_v[i]),
      .vc_head_o      (vc_head[i]),
      .vc_data_head_o (vc_data_head[i]),
      .read_en_i      (read_en[i]),
      .read_vc_id_i   (read_vc_id[i])
    );

    floo_sa_local #(
      .NumVC (NumVC)
    ) i_sa_local (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .vc_head_v_i    (vc_head_v[i]),
      .vc_head_i      (vc_head[i]),
      .out_vc_avail_i (out_vc_avail),
      .req_v_o        (sa_local_v[i]),
      .req_dir_oh_o   (sa_local_dir_oh[i]),
      .req_vc_id_o    (sa_local_vc_id[i]),
      .update_i       (read_en[i])
    );
  end

  // ==================================================
  // global allocation and credit tracking
  // ==================================================

  for (genvar o = 0; o < NumPorts; o++) begin : gen_out
    // requests that name this output, one bit per input
    for (genvar i = 0; i < NumPorts; i++) begin : gen_req
      assign req_v_per_out[o][i] = sa_local_v[i] & sa_local_dir_oh[i][o];
    end

    floo_sa_global i_sa_global (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .req_v_i       (req_v_per_out[o]),
      .req_vc_id_i   (sa_local_vc_id),
      .grant_v_o     (sa_global_v[o]),
      .grant_in_oh_o (sa_global_in_oh[o]),
      .grant_vc_id_o (sa_global_vc_id[o]),
      .update_i      (sa_global_v[o])
    );

    floo_vc_credit_tracker #(
      .NumVC   (NumVC),
      .VCDepth (VCDepth)
    ) i_credit_tracker (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .consume_i      (sa_global_v[o]),
      .credit_v_i     (credit_v_i[o]),
      .credit_id_i    (credit_id_i[o]),
      .out_vc_avail_o (out_vc_avail[o]),
      .out_vc_id_o    (out_vc_id[o])
    );
  end

  // ==================================================
  // switch traversal
  // ==================================================

  floo_switch_traversal #(
    .NumVC (NumVC)
  ) i_switch_traversal (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .xy_id_i        (xy_id_i),
    .grant_v_i      (sa_global_v),
    .grant_in_oh_i  (sa_global_in_oh),
    .grant_vc_id_i  (sa_global_vc_id),
    .out_vc_id_i    (out_vc_id),
    .vc_head_i      (vc_head),
    .vc_data_head_i (vc_data_head),
    .read_en_o      (read_en),
    .read_vc_id_o   (read_vc_id),
    .data_v_o       (data_v_o),
    .data_o         (data_o)
  );

endmodule

// File: bench/tb_floo_vc_router.sv
`timescale 1ns/100ps
// testbench for the VC mesh router with random traffic, credit models and a scoreboard
module tb_floo_vc_router;
  import floo_vc_pkg::*;

  localparam int NumVC         = 3;
  localparam int VCDepth       = 2;
  localparam int ClkPeriod     = 8;
  localparam int TrafficCycles = 1500;
  localparam int HoldWindow    = 60;
  localparam int DrainLimit    = 3000;
  localparam int NumKeys       = NumPorts * NumPorts * NumVC;
  // router sits in the middle of a 5x5 mesh at x 2 and y 2
  localparam coord_t Here = {3'd2, 3'd2};

  // expected flit kept per output and input vc
  typedef struct packed {
    coord_t                  dst;
    logic [PayloadWidth-1:0] payload;
    logic [31:0]             t_inj;
  } exp_t;

  logic                                 clk_i;
  logic                                 reset_i;
  coord_t                               xy_id_i;
  logic [NumPorts-1:0]                  credit_v_o;
  logic [NumPorts-1:0][VcIdWidth-1:0]   credit_id_o;
  logic [NumPorts-1:0][NumVC-1:0]       data_v_i;
  flit_t [NumPorts-1:0]                 data_i;
  logic [NumPorts-1:0]                  credit_v_i;
  logic [NumPorts-1:0][VcIdWidth-1:0]   credit_id_i;
  logic [NumPorts-1:0][NumVC-1:0]       data_v_o;
  flit_t [NumPorts-1:0]                 data_o;

  // upstream and downstream credit models
  int                    up_cred   [NumPorts][NumVC];
  int                    in_flight [NumPorts][NumVC];
  int                    ds_cred   [NumPorts][NumVC];
  int                    held_sent [NumPorts][NumVC];
  logic [VcIdWidth-1:0]  ret_q     [NumPorts][$];
  exp_t                  sb        [NumKeys][$];
  logic [31:0]           lfsr;
  bit                    hold;
  bit                    lat_mode;
  int                    errors;
  int                    timeouts;
  int                    inj_total;
  int                    out_total;

  floo_vc_router #(
    .NumVC   (NumVC),
    .VCDepth (VCDepth)
  ) i_dut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .xy_id_i     (xy_id_i),
    .credit_v_o  (credit_v_o),
    .credit_id_o (credit_id_o),
    .data_v_i    (data_v_i),
    .data_i      (data_i),
    .credit_v_i  (credit_v_i),
    .credit_id_i (credit_id_i),
    .data_v_o    (data_v_o),
    .data_o      (data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // ==================================================
  // helpers
  // ==================================================

  // galois lfsr stepped once per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // expected XY route with x resolved before y
  function automatic route_dir_e ref_route(coord_t from, coord_t dst);
    if (dst.x != from.x) return (dst.x > from.x) ? East : West;
    if (dst.y != from.y) return (dst.y > from.y) ? North : South;
    return Eject;
  endfunction

  // router reached through output dir while the local port stays here
  function automatic coord_t neighbor_of(coord_t from, int dir);
    coord_t n;
    n = from;
    if (dir == int'(North)) n.y = from.y + 3'd1;
    else if (dir == int'(South)) n.y = from.y - 3'd1;
    else if (dir == int'(East)) n.x = from.x + 3'd1;
    else if (dir == int'(West)) n.x = from.x - 3'd1;
    return n;
  endfunction

  function automatic int sb_key(int o, int i, int v);
    return (o * NumPorts + i) * NumVC + v;
  endfunction

  // all expected flits seen and all downstream credits handed back
  function automatic bit drained();
    for (int k = 0; k < NumKeys; k++) begin
      if (sb[k].size() != 0) return 1'b0;
    end
    for (int o = 0; o < NumPorts; o++) begin
      if (ret_q[o].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic report_mismatch(input string name, input longint got, input longint exp);
    $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("at %0t ns: %s", $time, what);
    errors++;
  endtask

  // ==================================================
  // stimulus with one call per clock cycle
  // ==================================================

  task automatic step_cycle(input bit traffic, input int one_port);
    flit_t                f;
    exp_t                 e;
    int                   vc;
    logic [VcIdWidth-1:0] id;
    @(posedge clk_i);
    // downstream returns one credit per output at random moments
    for (int o = 0; o < NumPorts; o++) begin
      credit_v_i[o] <= 1'b0;
      if (!hold && ret_q[o].size() > 0 && rand_bits(1) == 32'd1) begin
        id = ret_q[o].pop_front();
        credit_v_i[o]  <= 1'b1;
        credit_id_i[o] <= id;
        ds_cred[o][id]++;
      end
    end
    // upstream sends only on a vc it holds a credit for
    for (int i = 0; i < NumPorts; i++) begin
      data_v_i[i] <= '0;
      if (i == one_port || (traffic && rand_bits(1) == 32'd1)) begin
        vc = (i == one_port) ? 0 : int'(rand_bits(2)) % NumVC;
        if (up_cred[i][vc] > 0) begin
          f.hdr.dst.x     = 3'(rand_bits(3) % 5);
          f.hdr.dst.y     = 3'(rand_bits(3) % 5);
          f.hdr.lookahead = ref_route(Here, f.hdr.dst);
          f.hdr.vc_id     = VcIdWidth'(vc);
          f.payload       = rand_bits(PayloadWidth);
          data_v_i[i] <= NumVC'(1) << vc;
          data_i[i]   <= f;
          e.dst     = f.hdr.dst;
          e.payload = f.payload;
          e.t_inj   = 32'($time);
          sb[sb_key(int'(f.hdr.lookahead), i, vc)].push_back(e);
          up_cred[i][vc]--;
          in_flight[i][vc]++;
          inj_total++;
        end
      end
    end
  endtask

  task automatic wait_drained(input string what);
    int n;
    n = 0;
    while (!drained() && n < DrainLimit) begin
      step_cycle(1'b0, -1);
      n++;
    end
    if (!drained()) begin
      $display("timeout after %0d cycles waiting for %s", n, what);
      timeouts++;
    end
    // last returned credit still has to reach the DUT
    step_cycle(1'b0, -1);
  endtask

  // ==================================================
  // comparison at the falling edge where outputs are stable
  // ==================================================

  task automatic check_outputs();
    flit_t       f;
    exp_t        e;
    int          vc;
    int          key;
    bit          found;
    route_dir_e  exp_la;
    logic [31:0] lat;
    for (int o = 0; o < NumPorts; o++) begin
      if (inj_total == 0) begin
        assert (data_v_o[o] == '0) else report_mismatch("data_v_o", data_v_o[o], 0);
      end
      if (data_v_o[o] != '0) begin
        f  = data_o[o];
        vc = int'(f.hdr.vc_id);
        assert ($onehot(data_v_o[o])) else report_failure("data_v_o is not one-hot");
        assert (vc < NumVC && data_v_o[o][vc])
          else report_mismatch("data_v_o", data_v_o[o], longint'(1) << vc);
        if (vc < NumVC) begin
          assert (ds_cred[o][vc] > 0)
            else report_failure($sformatf("output %0d used vc %0d without credit", o, vc));
          ds_cred[o][vc]--;
          ret_q[o].push_back(VcIdWidth'(vc));
          // withheld credits cap what one vc may send
          if (hold) begin
            held_sent[o][vc]++;
            assert (held_sent[o][vc] <= VCDepth)
              else report_failure($sformatf("output %0d vc %0d overran back-pressure", o, vc));
          end
        end
        // head of some input vc queue for this output must match
        found = 1'b0;
        for (int i = 0; i < NumPorts && !found; i++) begin
          for (int v = 0; v < NumVC && !found; v++) begin
            key = sb_key(o, i, v);
            if (sb[key].size() > 0 && sb[key][0].dst == f.hdr.dst &&
                sb[key][0].payload == f.payload) begin
              found = 1'b1;
              e = sb[key].pop_front();
            end
          end
        end
        assert (found)
          else report_failure($sformatf("payload %0h on output %0d unexpected or out of order",
                                        f.payload, o));
        if (found) begin
          out_total++;
          exp_la = ref_route(neighbor_of(Here, o), e.dst);
          assert (f.hdr.lookahead == exp_la)
            else report_mismatch("data_o.hdr.lookahead", f.hdr.lookahead, exp_la);
          if (lat_mode) begin
            lat = 32'($time) - e.t_inj - 32'(ClkPeriod / 2);
            assert (lat == 32'(2 * ClkPeriod)) else report_mismatch("latency_ns", lat, 2 * ClkPeriod);
          end
        end
      end
    end
    for (int i = 0; i < NumPorts; i++) begin
      if (inj_total == 0) begin
        assert (!credit_v_o[i]) else report_mismatch("credit_v_o", credit_v_o[i], 0);
      end
      if (credit_v_o[i]) begin
        vc = int'(credit_id_o[i]);
        assert (vc < NumVC && in_flight[i][vc] > 0)
          else report_failure($sformatf("input %0d returned a credit for empty vc %0d", i, vc));
        if (vc < NumVC) begin
          in_flight[i][vc]--;
          up_cred[i][vc]++;
        end
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (!reset_i) check_outputs();
  end

  // ==================================================
  // test sequence
  // ==================================================

  initial begin
    reset_i     = 1'b1;
    xy_id_i     = Here;
    data_v_i    = '0;
    data_i      = '0;
    credit_v_i  = '0;
    credit_id_i = '0;
    lfsr        = 32'd73464;
    hold        = 1'b0;
    lat_mode    = 1'b0;
    errors      = 0;
    timeouts    = 0;
    inj_total   = 0;
    out_total   = 0;
    for (int p = 0; p < NumPorts; p++) begin
      for (int v = 0; v < NumVC; v++) begin
        up_cred[p][v]   = VCDepth;
        ds_cred[p][v]   = VCDepth;
        in_flight[p][v] = 0;
        held_sent[p][v] = 0;
      end
    end
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    // nothing may come out of an idle router
    repeat (5) step_cycle(1'b0, -1);
    // lone flits on an empty router with full credits
    lat_mode = 1'b1;
    for (int i = 0; i < NumPorts && timeouts == 0; i++) begin
      step_cycle(1'b0, i);
      wait_drained("a single flit");
    end
    lat_mode = 1'b0;
    if (timeouts == 0) begin
      for (int c = 0; c < TrafficCycles; c++) begin
        // some windows hold all downstream credits back
        if (c % HoldWindow == 0) begin
          hold = (rand_bits(2) == 32'd0);
          for (int o = 0; o < NumPorts; o++) begin
            for (int v = 0; v < NumVC; v++) begin
              held_sent[o][v] = 0;
            end
          end
        end
        step_cycle(1'b1, -1);
      end
      hold = 1'b0;
      wait_drained("the router to drain");
    end
    for (int i = 0; i < NumPorts; i++) begin
      for (int v = 0; v < NumVC; v++) begin
        assert (up_cred[i][v] == VCDepth)
          else report_mismatch($sformatf("up_cred[%0d][%0d]", i, v), up_cred[i][v], VCDepth);
      end
    end
    assert (out_total == inj_total) else report_mismatch("delivered", out_total, inj_total);
    $display("injected %0d, delivered %0d, errors %0d, timeouts %0d",
             inj_total, out_total, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: files.f
src/floo_vc_pkg.sv
src/floo_input_port.sv
src/floo_sa_local.sv
src/floo_sa_global.sv
src/floo_vc_credit_tracker.sv
src/floo_switch_traversal.sv
src/floo_vc_router.sv
bench/tb_floo_vc_router.sv

// File: run_sim.sh
#!/bin/sh
# build and run the router testbench with Verilator, the log decides the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_floo_vc_router \
  -f files.f -o tb_floo_vc_router > sim.log 2>&1 &&
  ./obj_dir/tb_floo_vc_router >> sim.log 2>&1 ||
  { echo "build or simulation aborted, see sim.log"; exit 1; }
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
